// ==== common/retire_trace_pkg.sv ====
//////////////////////////////////////////////////
// Widths here are fixed by the trace format
// Changing them breaks the record layout
//////////////////////////////////////////////////

package retire_trace_pkg;

  localparam int unsigned XLEN       = 32;
  localparam int unsigned REG_ADDR_W = 5;
  localparam int unsigned ORDER_W    = 64;
  localparam int unsigned MASK_W     = 4;

  // Next-PC source
  typedef enum logic [2:0] {
    PC_BOOT,
    PC_JUMP,
    PC_EXC,
    PC_ERET,
    PC_DRET
  } pc_sel_e;

  // Exception-PC source
  typedef enum logic [1:0] {
    EXC_PC_EXC,
    EXC_PC_IRQ,
    EXC_PC_DBD,
    EXC_PC_DBG_EXC
  } exc_pc_sel_e;

  // Access size, value 3 is reserved
  typedef enum logic [1:0] {
    MEM_WORD = 2'd0,
    MEM_HALF = 2'd1,
    MEM_BYTE = 2'd2
  } mem_size_e;

  function automatic logic [MASK_W-1:0] size_to_mask(mem_size_e size);
    logic [MASK_W-1:0] mask;
    case (size)
      MEM_WORD: mask = 4'b1111;
      MEM_HALF: mask = 4'b0011;
      MEM_BYTE: mask = 4'b0001;
      default:  mask = 4'b0000;
    endcase
    return mask;
  endfunction

endpackage

// ==== logic/retire_trace_top.sv ====
//////////////////////////////////////////////////
// Retirement tracer and sleep control
// Inputs are per-cycle strobes and levels
//////////////////////////////////////////////////

`timescale 1ns/1ps

module retire_trace_top import retire_trace_pkg::*; (
  input  logic                  clk,
  input  logic                  rst_ni,
  // Instruction events
  input  logic                  instr_new_i,
  input  logic                  instr_ret_i,
  input  logic                  instr_is_compressed_i,
  input  logic [XLEN-1:0]       instr_rdata_i,
  input  logic [15:0]           instr_rdata_c_i,
  input  logic                  illegal_insn_i,
  // PC events
  input  logic                  pc_set_i,
  input  pc_sel_e               pc_mux_i,
  input  exc_pc_sel_e           exc_pc_mux_i,
  input  logic [XLEN-1:0]       pc_if_i,
  input  logic [XLEN-1:0]       pc_id_i,
  // Register file values
  input  logic [REG_ADDR_W-1:0] rs1_addr_i,
  input  logic [REG_ADDR_W-1:0] rs2_addr_i,
  input  logic [XLEN-1:0]       rs1_rdata_i,
  input  logic [XLEN-1:0]       rs2_rdata_i,
  input  logic [REG_ADDR_W-1:0] rd_addr_i,
  input  logic [XLEN-1:0]       rd_wdata_i,
  input  logic                  rd_we_i,
  // LSU values
  input  logic                  lsu_data_valid_i,
  input  mem_size_e             data_size_i,
  input  logic                  data_we_i,
  input  logic [XLEN-1:0]       lsu_addr_i,
  input  logic [XLEN-1:0]       lsu_rdata_i,
  input  logic [XLEN-1:0]       lsu_wdata_i,
  // Sleep sources
  input  logic                  if_busy_i,
  input  logic                  ctrl_busy_i,
  input  logic                  lsu_busy_i,
  input  logic                  firstfetch_i,
  input  logic                  debug_req_i,
  input  logic                  irq_pending_i,
  input  logic                  irq_nm_i,
  output logic                  core_sleep_o,
  // Trace record
  output logic                  rvfi_valid_o,
  output logic [ORDER_W-1:0]    rvfi_order_o,
  output logic [XLEN-1:0]       rvfi_insn_o,
  output logic                  rvfi_trap_o,
  output logic                  rvfi_intr_o,
  output logic [REG_ADDR_W-1:0] rvfi_rs1_addr_o,
  output logic [REG_ADDR_W-1:0] rvfi_rs2_addr_o,
  output logic [XLEN-1:0]       rvfi_rs1_rdata_o,
  output logic [XLEN-1:0]       rvfi_rs2_rdata_o,
  output logic [REG_ADDR_W-1:0] rvfi_rd_addr_o,
  output logic [XLEN-1:0]       rvfi_rd_wdata_o,
  output logic [XLEN-1:0]       rvfi_pc_rdata_o,
  output logic [XLEN-1:0]       rvfi_pc_wdata_o,
  output logic [XLEN-1:0]       rvfi_mem_addr_o,
  output logic [MASK_W-1:0]     rvfi_mem_rmask_o,
  output logic [MASK_W-1:0]     rvfi_mem_wmask_o,
  output logic [XLEN-1:0]       rvfi_mem_rdata_o,
  output logic [XLEN-1:0]       rvfi_mem_wdata_o
);

  logic                  insn_open;
  logic                  intr_next;
  logic [XLEN-1:0]       rs1_data;
  logic [XLEN-1:0]       rs2_data;
  logic [REG_ADDR_W-1:0] rd_addr;
  logic [XLEN-1:0]       rd_data;
  logic [MASK_W-1:0]     mem_mask;
  logic [XLEN-1:0]       mem_addr;
  logic [XLEN-1:0]       mem_rdata;
  logic [XLEN-1:0]       mem_wdata;

  //////////////////////////////////////////////////
  // Tracer
  //////////////////////////////////////////////////

  // Same-named ports connect implicitly, internal nets are listed
  insn_track u_insn_track (
    .*,
    .insn_open_o (insn_open),
    .intr_next_o (intr_next)
  );

  operand_hold u_operand_hold (
    .*,
    .insn_open_i (insn_open),
    .rs1_data_o  (rs1_data),
    .rs2_data_o  (rs2_data),
    .rd_addr_o   (rd_addr),
    .rd_data_o   (rd_data)
  );

  mem_hold u_mem_hold (
    .*,
    .insn_open_i (insn_open),
    .mem_mask_o  (mem_mask),
    .mem_addr_o  (mem_addr),
    .mem_rdata_o (mem_rdata),
    .mem_wdata_o (mem_wdata)
  );

  // rd_addr_i here is the held address, not the raw input
  trace_out_reg u_trace_out_reg (
    .*,
    .intr_next_i (intr_next),
    .rs1_data_i  (rs1_data),
    .rs2_data_i  (rs2_data),
    .rd_addr_i   (rd_addr),
    .rd_data_i   (rd_data),
    .mem_mask_i  (mem_mask),
    .mem_addr_i  (mem_addr),
    .mem_rdata_i (mem_rdata),
    .mem_wdata_i (mem_wdata)
  );

  //////////////////////////////////////////////////
  // Sleep control
  //////////////////////////////////////////////////

  sleep_ctrl u_sleep_ctrl (
    .*
  );

endmodule

// ==== logic/sleep_ctrl.sv ====
//////////////////////////////////////////////////
// Busy sources count one cycle late
// Wake sources act in the same cycle
//////////////////////////////////////////////////

`timescale 1ns/1ps

module sleep_ctrl (
  input  logic clk,
  input  logic rst_ni,
  input  logic if_busy_i,
  input  logic ctrl_busy_i,
  input  logic lsu_busy_i,
  input  logic firstfetch_i,
  input  logic debug_req_i,
  input  logic irq_pending_i,
  input  logic irq_nm_i,
  output logic core_sleep_o
);

  logic busy_q;

  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q <= 1'b0;
    end else begin
      busy_q <= if_busy_i | ctrl_busy_i | lsu_busy_i;
    end
  end

  assign core_sleep_o = ~(firstfetch_i | busy_q | debug_req_i | irq_pending_i | irq_nm_i);

endmodule

// ==== retire_trace.f ====
common/retire_trace_pkg.sv
rvfi_trace/insn_track.sv
rvfi_trace/operand_hold.sv
rvfi_trace/mem_hold.sv
rvfi_trace/trace_out_reg.sv
logic/sleep_ctrl.sv
logic/retire_trace_top.sv
verif/retire_trace_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds and runs retire_trace_tb with Verilator, pass or fail from the log
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f retire_trace.f \
  --top-module retire_trace_tb -Mdir obj_dir -o retire_trace_sim
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

./obj_dir/retire_trace_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "^Result: PASSED$" sim.log; then
  exit 0
fi
echo "pass message not found in sim.log"
exit 1

// ==== rvfi_trace/insn_track.sv ====
//////////////////////////////////////////////////
// Open-instruction and trap-entry tracking
// insn_open_o and intr_next_o are combinational
//////////////////////////////////////////////////

`timescale 1ns/1ps

module insn_track import retire_trace_pkg::*; (
  input  logic        clk,
  input  logic        rst_ni,
  input  logic        instr_new_i,
  input  logic        instr_ret_i,
  input  logic        pc_set_i,
  input  pc_sel_e     pc_mux_i,
  input  exc_pc_sel_e exc_pc_mux_i,
  output logic        insn_open_o,
  output logic        intr_next_o
);

  logic insn_open_q;
  logic trap_q;
  logic trap_d;
  logic trap_entry;

  // Open from the new strobe up to the retire edge
  assign insn_open_o = instr_new_i | insn_open_q;

  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      insn_open_q <= 1'b0;
    end else if (instr_ret_i) begin
      insn_open_q <= 1'b0;
    end else begin
      insn_open_q <= insn_open_o;
    end
  end

  // PC redirected into a trap handler, debug entries excluded
  assign trap_entry = pc_set_i && (pc_mux_i == PC_EXC) &&
                      ((exc_pc_mux_i == EXC_PC_EXC) || (exc_pc_mux_i == EXC_PC_IRQ));

  always_comb begin
    trap_d = trap_q;
    if (trap_entry) begin
      trap_d = 1'b1;
    end else if (trap_q && instr_ret_i) begin
      // First handler instruction has retired
      trap_d = 1'b0;
    end
  end

  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      trap_q <= 1'b0;
    end else begin
      trap_q <= trap_d;
    end
  end

  assign intr_next_o = trap_q & insn_open_o;

  // Retire only follows an earlier or same-cycle instr_new_i
  assert property (@(posedge clk) disable iff (!rst_ni) instr_ret_i |-> insn_open_o);

endmodule

// ==== rvfi_trace/mem_hold.sv ====
//////////////////////////////////////////////////
// Memory record of the open instruction
// Reserved size gives an empty mask
//////////////////////////////////////////////////

`timescale 1ns/1ps

module mem_hold import retire_trace_pkg::*; (
  input  logic              clk,
  input  logic              rst_ni,
  input  logic              insn_open_i,
  input  logic              lsu_data_valid_i,
  input  mem_size_e         data_size_i,
  input  logic [XLEN-1:0]   lsu_addr_i,
  input  logic [XLEN-1:0]   lsu_rdata_i,
  input  logic [XLEN-1:0]   lsu_wdata_i,
  output logic [MASK_W-1:0] mem_mask_o,
  output logic [XLEN-1:0]   mem_addr_o,
  output logic [XLEN-1:0]   mem_rdata_o,
  output logic [XLEN-1:0]   mem_wdata_o
);

  logic            mem_upd;
  logic [XLEN-1:0] mem_addr_q;
  logic [XLEN-1:0] mem_rdata_q;
  logic [XLEN-1:0] mem_wdata_q;

  assign mem_mask_o = size_to_mask(data_size_i);

  // Take LSU values only for the open instruction
  assign mem_upd     = insn_open_i & lsu_data_valid_i;
  assign mem_addr_o  = mem_upd ? lsu_addr_i  : mem_addr_q;
  assign mem_rdata_o = mem_upd ? lsu_rdata_i : mem_rdata_q;
  assign mem_wdata_o = mem_upd ? lsu_wdata_i : mem_wdata_q;

  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      mem_addr_q  <= '0;
      mem_rdata_q <= '0;
      mem_wdata_q <= '0;
    end else begin
      mem_addr_q  <= mem_addr_o;
      mem_rdata_q <= mem_rdata_o;
      mem_wdata_q <= mem_wdata_o;
    end
  end

  // LSU must report a legal size with its data
  assert property (@(posedge clk) disable iff (!rst_ni)
                   lsu_data_valid_i |-> (2'(data_size_i) != 2'b11));

endmodule

// ==== rvfi_trace/operand_hold.sv ====
//////////////////////////////////////////////////
// Outputs are next-state values, the trace
// stage registers them once
//////////////////////////////////////////////////

`timescale 1ns/1ps

module operand_hold import retire_trace_pkg::*; (
  input  logic                  clk,
  input  logic                  rst_ni,
  input  logic                  instr_new_i,
  input  logic                  insn_open_i,
  input  logic [XLEN-1:0]       rs1_rdata_i,
  input  logic [XLEN-1:0]       rs2_rdata_i,
  input  logic                  rd_we_i,
  input  logic [REG_ADDR_W-1:0] rd_addr_i,
  input  logic [XLEN-1:0]       rd_wdata_i,
  output logic [XLEN-1:0]       rs1_data_o,
  output logic [XLEN-1:0]       rs2_data_o,
  output logic [REG_ADDR_W-1:0] rd_addr_o,
  output logic [XLEN-1:0]       rd_data_o
);

  logic [XLEN-1:0]       rs1_data_q;
  logic [XLEN-1:0]       rs2_data_q;
  logic [REG_ADDR_W-1:0] rd_addr_q;
  logic [XLEN-1:0]       rd_data_q;

  // Sources sampled once at instruction start
  assign rs1_data_o = instr_new_i ? rs1_rdata_i : rs1_data_q;
  assign rs2_data_o = instr_new_i ? rs2_rdata_i : rs2_data_q;

  // Destination follows the core while the instruction is open
  always_comb begin
    rd_addr_o = rd_addr_q;
    rd_data_o = rd_data_q;
    if (insn_open_i) begin
      if (!rd_we_i) begin
        rd_addr_o = '0;
        rd_data_o = '0;
      end else begin
        rd_addr_o = rd_addr_i;
        // x0 never holds a value
        rd_data_o = (rd_addr_i == '0) ? '0 : rd_wdata_i;
      end
    end
  end

  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      rs1_data_q <= '0;
      rs2_data_q <= '0;
      rd_addr_q  <= '0;
      rd_data_q  <= '0;
    end else begin
      rs1_data_q <= rs1_data_o;
      rs2_data_q <= rs2_data_o;
      rd_addr_q  <= rd_addr_o;
      rd_data_q  <= rd_data_o;
    end
  end

endmodule

// ==== rvfi_trace/trace_out_reg.sv ====
//////////////////////////////////////////////////
// One record per retire, one cycle after it
// No back-pressure, sampled every cycle
//////////////////////////////////////////////////

`timescale 1ns/1ps

module trace_out_reg import retire_trace_pkg::*; (
  input  logic                  clk,
  input  logic                  rst_ni,
  input  logic                  instr_ret_i,
  input  logic                  illegal_insn_i,
  input  logic                  intr_next_i,
  input  logic                  instr_is_compressed_i,
  input  logic [XLEN-1:0]       instr_rdata_i,
  input  logic [15:0]           instr_rdata_c_i,
  input  logic [REG_ADDR_W-1:0] rs1_addr_i,
  input  logic [REG_ADDR_W-1:0] rs2_addr_i,
  input  logic [XLEN-1:0]       rs1_data_i,
  input  logic [XLEN-1:0]       rs2_data_i,
  input  logic [REG_ADDR_W-1:0] rd_addr_i,
  input  logic [XLEN-1:0]       rd_data_i,
  input  logic [XLEN-1:0]       pc_id_i,
  input  logic [XLEN-1:0]       pc_if_i,
  input  logic [MASK_W-1:0]     mem_mask_i,
  input  logic                  data_we_i,
  input  logic [XLEN-1:0]       mem_addr_i,
  input  logic [XLEN-1:0]       mem_rdata_i,
  input  logic [XLEN-1:0]       mem_wdata_i,
  output logic                  rvfi_valid_o,
  output logic [ORDER_W-1:0]    rvfi_order_o,
  output logic [XLEN-1:0]       rvfi_insn_o,
  output logic                  rvfi_trap_o,
  output logic                  rvfi_intr_o,
  output logic [REG_ADDR_W-1:0] rvfi_rs1_addr_o,
  output logic [REG_ADDR_W-1:0] rvfi_rs2_addr_o,
  output logic [XLEN-1:0]       rvfi_rs1_rdata_o,
  output logic [XLEN-1:0]       rvfi_rs2_rdata_o,
  output logic [REG_ADDR_W-1:0] rvfi_rd_addr_o,
  output logic [XLEN-1:0]       rvfi_rd_wdata_o,
  output logic [XLEN-1:0]       rvfi_pc_rdata_o,
  output logic [XLEN-1:0]       rvfi_pc_wdata_o,
  output logic [XLEN-1:0]       rvfi_mem_addr_o,
  output logic [MASK_W-1:0]     rvfi_mem_rmask_o,
  output logic [MASK_W-1:0]     rvfi_mem_wmask_o,
  output logic [XLEN-1:0]       rvfi_mem_rdata_o,
  output logic [XLEN-1:0]       rvfi_mem_wdata_o
);

  logic [XLEN-1:0] insn_word;

  // Compressed encodings are zero-extended
  assign insn_word = instr_is_compressed_i ? {16'b0, instr_rdata_c_i} : instr_rdata_i;

  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      rvfi_valid_o     <= 1'b0;
      rvfi_order_o     <= '0;
      rvfi_insn_o      <= '0;
      rvfi_trap_o      <= 1'b0;
      rvfi_intr_o      <= 1'b0;
      rvfi_rs1_addr_o  <= '0;
      rvfi_rs2_addr_o  <= '0;
      rvfi_rs1_rdata_o <= '0;
      rvfi_rs2_rdata_o <= '0;
      rvfi_rd_addr_o   <= '0;
      rvfi_rd_wdata_o  <= '0;
      rvfi_pc_rdata_o  <= '0;
      rvfi_pc_wdata_o  <= '0;
      rvfi_mem_addr_o  <= '0;
      rvfi_mem_rmask_o <= '0;
      rvfi_mem_wmask_o <= '0;
      rvfi_mem_rdata_o <= '0;
      rvfi_mem_wdata_o <= '0;
    end else begin
      rvfi_valid_o     <= instr_ret_i;
      // Counts the records already sent
      rvfi_order_o     <= rvfi_order_o + ORDER_W'(rvfi_valid_o);
      rvfi_insn_o      <= insn_word;
      rvfi_trap_o      <= illegal_insn_i;
      rvfi_intr_o      <= intr_next_i;
      rvfi_rs1_addr_o  <= rs1_addr_i;
      rvfi_rs2_addr_o  <= rs2_addr_i;
      rvfi_rs1_rdata_o <= rs1_data_i;
      rvfi_rs2_rdata_o <= rs2_data_i;
      rvfi_rd_addr_o   <= rd_addr_i;
      rvfi_rd_wdata_o  <= rd_data_i;
      rvfi_pc_rdata_o  <= pc_id_i;
      rvfi_pc_wdata_o  <= pc_if_i;
      rvfi_mem_addr_o  <= mem_addr_i;
      rvfi_mem_rmask_o <= mem_mask_i;
      rvfi_mem_wmask_o <= data_we_i ? mem_mask_i : '0;
      rvfi_mem_rdata_o <= mem_rdata_i;
      rvfi_mem_wdata_o <= mem_wdata_i;
    end
  end

  // Order moves only right after a valid record
  assert property (@(posedge clk) disable iff (!rst_ni)
                   (rvfi_order_o != $past(rvfi_order_o)) |-> $past(rvfi_valid_o));

endmodule

// ==== verif/retire_trace_tb.sv ====
//////////////////////////////////////////////////
// Control comes from the row table, data words
// are random from a fixed seed
// Record fields are compared only on valid cycles
//////////////////////////////////////////////////

`timescale 1ns/1ps

module retire_trace_tb import retire_trace_pkg::*; ();

  localparam int PERIOD       = 100;
  localparam int RESET_CYCLES = 16;

  // Instruction event columns, ORed together in the table
  localparam logic [3:0] EV_NONE = 4'b0000;
  localparam logic [3:0] EV_NEW  = 4'b1000;
  localparam logic [3:0] EV_RET  = 4'b0100;
  localparam logic [3:0] EV_ONE  = 4'b1100;
  localparam logic [3:0] EV_COMP = 4'b0010;
  localparam logic [3:0] EV_ILL  = 4'b0001;
  localparam logic [5:0] NO_PC   = 6'b000000;
  localparam logic [3:0] NO_LSU  = 4'b0000;
  localparam logic [6:0] AWAKE   = 7'b0000000;

  logic                  clk;
  logic                  rst_ni;
  logic                  instr_new_i;
  logic                  instr_ret_i;
  logic                  instr_is_compressed_i;
  logic [XLEN-1:0]       instr_rdata_i;
  logic [15:0]           instr_rdata_c_i;
  logic                  illegal_insn_i;
  logic                  pc_set_i;
  pc_sel_e               pc_mux_i;
  exc_pc_sel_e           exc_pc_mux_i;
  logic [XLEN-1:0]       pc_if_i;
  logic [XLEN-1:0]       pc_id_i;
  logic [REG_ADDR_W-1:0] rs1_addr_i;
  logic [REG_ADDR_W-1:0] rs2_addr_i;
  logic [XLEN-1:0]       rs1_rdata_i;
  logic [XLEN-1:0]       rs2_rdata_i;
  logic [REG_ADDR_W-1:0] rd_addr_i;
  logic [XLEN-1:0]       rd_wdata_i;
  logic                  rd_we_i;
  logic                  lsu_data_valid_i;
  mem_size_e             data_size_i;
  logic                  data_we_i;
  logic [XLEN-1:0]       lsu_addr_i;
  logic [XLEN-1:0]       lsu_rdata_i;
  logic [XLEN-1:0]       lsu_wdata_i;
  logic                  if_busy_i;
  logic                  ctrl_busy_i;
  logic                  lsu_busy_i;
  logic                  firstfetch_i;
  logic                  debug_req_i;
  logic                  irq_pending_i;
  logic                  irq_nm_i;
  logic                  core_sleep_o;
  logic                  rvfi_valid_o;
  logic [ORDER_W-1:0]    rvfi_order_o;
  logic [XLEN-1:0]       rvfi_insn_o;
  logic                  rvfi_trap_o;
  logic                  rvfi_intr_o;
  logic [REG_ADDR_W-1:0] rvfi_rs1_addr_o;
  logic [REG_ADDR_W-1:0] rvfi_rs2_addr_o;
  logic [XLEN-1:0]       rvfi_rs1_rdata_o;
  logic [XLEN-1:0]       rvfi_rs2_rdata_o;
  logic [REG_ADDR_W-1:0] rvfi_rd_addr_o;
  logic [XLEN-1:0]       rvfi_rd_wdata_o;
  logic [XLEN-1:0]       rvfi_pc_rdata_o;
  logic [XLEN-1:0]       rvfi_pc_wdata_o;
  logic [XLEN-1:0]       rvfi_mem_addr_o;
  logic [MASK_W-1:0]     rvfi_mem_rmask_o;
  logic [MASK_W-1:0]     rvfi_mem_wmask_o;
  logic [XLEN-1:0]       rvfi_mem_rdata_o;
  logic [XLEN-1:0]       rvfi_mem_wdata_o;

  // ev: new, ret, compressed, illegal
  // pc: set, pc_mux, exc_pc_mux
  // rd: we, addr   lsu: valid, size, we
  // slp: if/ctrl/lsu busy, firstfetch, debug, irq pending, nmi
  typedef struct packed {
    logic [3:0] ev;
    logic [5:0] pc;
    logic [5:0] rd;
    logic [3:0] lsu;
    logic [6:0] slp;
  } row_t;

  typedef struct packed {
    logic                  valid;
    logic [ORDER_W-1:0]    order;
    logic [XLEN-1:0]       insn;
    logic                  trap;
    logic                  intr;
    logic [REG_ADDR_W-1:0] rs1_addr;
    logic [REG_ADDR_W-1:0] rs2_addr;
    logic [XLEN-1:0]       rs1_data;
    logic [XLEN-1:0]       rs2_data;
    logic [REG_ADDR_W-1:0] rd_addr;
    logic [XLEN-1:0]       rd_data;
    logic [XLEN-1:0]       pc_rdata;
    logic [XLEN-1:0]       pc_wdata;
    logic [XLEN-1:0]       mem_addr;
    logic [MASK_W-1:0]     rmask;
    logic [MASK_W-1:0]     wmask;
    logic [XLEN-1:0]       mem_rdata;
    logic [XLEN-1:0]       mem_wdata;
  } rec_t;

  row_t  rows[$];
  string row_names[$];
  rec_t  exp_rec;
  string prev_name;
  bit    table_ready;
  int    n_checks;
  int    n_errors;

  // Model state, mirrors what the tracer holds between cycles
  logic                  m_open;
  logic                  m_trap;
  logic                  m_busy;
  logic [XLEN-1:0]       m_rs1;
  logic [XLEN-1:0]       m_rs2;
  logic [REG_ADDR_W-1:0] m_rd_addr;
  logic [XLEN-1:0]       m_rd_data;
  logic [XLEN-1:0]       m_addr;
  logic [XLEN-1:0]       m_rdata;
  logic [XLEN-1:0]       m_wdata;

  retire_trace_top DUT (.*);

  initial begin
    clk = 1'b0;
    forever #(PERIOD / 2) clk = ~clk;
  end

  //////////////////////////////////////////////////
  // Compare tasks
  //////////////////////////////////////////////////

  task automatic check_bit(string name, logic exp, logic act);
    n_checks++;
    if (act !== exp) begin
      n_errors++;
      $display("error %s expected %0b actual %0b", name, exp, act);
    end
  endtask

  task automatic check_word(string name, logic [XLEN-1:0] exp, logic [XLEN-1:0] act);
    n_checks++;
    if (act !== exp) begin
      n_errors++;
      $display("error %s expected %08h actual %08h", name, exp, act);
    end
  endtask

  task automatic check_mask(string name, logic [MASK_W-1:0] exp, logic [MASK_W-1:0] act);
    n_checks++;
    if (act !== exp) begin
      n_errors++;
      $display("error %s expected %04b actual %04b", name, exp, act);
    end
  endtask

  task automatic check_order(string name, logic [ORDER_W-1:0] exp, logic [ORDER_W-1:0] act);
    n_checks++;
    if (act !== exp) begin
      n_errors++;
      $display("error %s expected %0d actual %0d", name, exp, act);
    end
  endtask

  task automatic check_record(string name);
    check_bit({name, ".valid"}, exp_rec.valid, rvfi_valid_o);
    check_order({name, ".order"}, exp_rec.order, rvfi_order_o);
    check_bit({name, ".trap"}, exp_rec.trap, rvfi_trap_o);
    check_bit({name, ".intr"}, exp_rec.intr, rvfi_intr_o);
    if (exp_rec.valid) begin
      check_word({name, ".insn"}, exp_rec.insn, rvfi_insn_o);
      check_word({name, ".rs1_addr"}, XLEN'(exp_rec.rs1_addr), XLEN'(rvfi_rs1_addr_o));
      check_word({name, ".rs2_addr"}, XLEN'(exp_rec.rs2_addr), XLEN'(rvfi_rs2_addr_o));
      check_word({name, ".rs1_rdata"}, exp_rec.rs1_data, rvfi_rs1_rdata_o);
      check_word({name, ".rs2_rdata"}, exp_rec.rs2_data, rvfi_rs2_rdata_o);
      check_word({name, ".rd_addr"}, XLEN'(exp_rec.rd_addr), XLEN'(rvfi_rd_addr_o));
      check_word({name, ".rd_wdata"}, exp_rec.rd_data, rvfi_rd_wdata_o);
      check_word({name, ".pc_rdata"}, exp_rec.pc_rdata, rvfi_pc_rdata_o);
      check_word({name, ".pc_wdata"}, exp_rec.pc_wdata, rvfi_pc_wdata_o);
      check_word({name, ".mem_addr"}, exp_rec.mem_addr, rvfi_mem_addr_o);
      check_mask({name, ".rmask"}, exp_rec.rmask, rvfi_mem_rmask_o);
      check_mask({name, ".wmask"}, exp_rec.wmask, rvfi_mem_wmask_o);
      check_word({name, ".mem_rdata"}, exp_rec.mem_rdata, rvfi_mem_rdata_o);
      check_word({name, ".mem_wdata"}, exp_rec.mem_wdata, rvfi_mem_wdata_o);
    end
  endtask

  //////////////////////////////////////////////////
  // Stimulus and model
  //////////////////////////////////////////////////

  task automatic add_row(string name, logic [3:0] ev, logic [5:0] pc, logic [5:0] rd,
                         logic [3:0] lsu, logic [6:0] slp);
    rows.push_back({ev, pc, rd, lsu, slp});
    row_names.push_back(name);
  endtask

  task automatic build_table();
    add_row("sleep_idle",      EV_NONE,          NO_PC, 6'd0,        NO_LSU, AWAKE);
    add_row("sleep_nmi",       EV_NONE,          NO_PC, 6'd0,        NO_LSU, 7'b0000001);
    add_row("sleep_busy",      EV_NONE,          NO_PC, 6'd0,        NO_LSU, 7'b1000000);
    add_row("sleep_busy_late", EV_NONE,          NO_PC, 6'd0,        NO_LSU, AWAKE);
    add_row("sleep_firstfetch", EV_NONE,         NO_PC, 6'd0,        NO_LSU, 7'b0001000);
    add_row("sleep_ctrl_busy", EV_NONE,          NO_PC, 6'd0,        NO_LSU, 7'b0100000);
    add_row("sleep_ctrl_late", EV_NONE,          NO_PC, 6'd0,        NO_LSU, AWAKE);
    add_row("sleep_lsu_busy",  EV_NONE,          NO_PC, 6'd0,        NO_LSU, 7'b0010000);
    add_row("sleep_lsu_late",  EV_NONE,          NO_PC, 6'd0,        NO_LSU, AWAKE);
    add_row("sleep_debug",     EV_NONE,          NO_PC, 6'd0,        NO_LSU, 7'b0000100);
    add_row("sleep_irq",       EV_NONE,          NO_PC, 6'd0,        NO_LSU, 7'b0000010);
    add_row("seq_a_new",       EV_NEW,           NO_PC, {1'b1, 5'd5}, NO_LSU, AWAKE);
    add_row("seq_a_ret",       EV_RET,           NO_PC, {1'b1, 5'd5}, NO_LSU, AWAKE);
    add_row("seq_b",           EV_ONE,           NO_PC, {1'b1, 5'd7}, NO_LSU, AWAKE);
    add_row("seq_c_comp",      EV_ONE | EV_COMP, NO_PC, {1'b1, 5'd3}, NO_LSU, AWAKE);
    add_row("hold_new",        EV_NEW,           NO_PC, {1'b1, 5'd9}, NO_LSU, AWAKE);
    add_row("hold_mid",        EV_NONE,          NO_PC, {1'b1, 5'd9}, NO_LSU, AWAKE);
    add_row("hold_ret",        EV_RET,           NO_PC, {1'b1, 5'd9}, NO_LSU, AWAKE);
    add_row("rd_nowrite",      EV_ONE,           NO_PC, {1'b0, 5'd4}, NO_LSU, AWAKE);
    add_row("rd_x0",           EV_ONE,           NO_PC, {1'b1, 5'd0}, NO_LSU, AWAKE);
    add_row("mem_word_load",   EV_NEW,  NO_PC, 6'd0, {1'b1, MEM_WORD, 1'b0}, AWAKE);
    add_row("mem_word_ret",    EV_RET,  NO_PC, 6'd0, {1'b0, MEM_WORD, 1'b0}, AWAKE);
    add_row("mem_half_store",  EV_NEW,  NO_PC, 6'd0, {1'b1, MEM_HALF, 1'b1}, AWAKE);
    add_row("mem_half_ret",    EV_RET,  NO_PC, 6'd0, {1'b0, MEM_HALF, 1'b1}, AWAKE);
    add_row("mem_byte_store",  EV_ONE,  NO_PC, 6'd0, {1'b1, MEM_BYTE, 1'b1}, AWAKE);
    add_row("mem_byte_load",   EV_NEW,  NO_PC, 6'd0, {1'b1, MEM_BYTE, 1'b0}, AWAKE);
    add_row("mem_byte_hold",   EV_NONE, NO_PC, 6'd0, {1'b0, MEM_BYTE, 1'b0}, AWAKE);
    add_row("mem_byte_ret",    EV_RET,  NO_PC, 6'd0, {1'b0, MEM_BYTE, 1'b0}, AWAKE);
    // LSU data with no open instruction must not reach the record
    add_row("mem_idle_valid",  EV_NONE, NO_PC, 6'd0, {1'b1, MEM_HALF, 1'b0}, AWAKE);
    add_row("mem_idle_ret",    EV_ONE,  NO_PC, 6'd0, NO_LSU,                 AWAKE);
    add_row("irq_set",    EV_NONE, {1'b1, PC_EXC, EXC_PC_IRQ}, 6'd0, NO_LSU, AWAKE);
    add_row("irq_wait",   EV_NONE, NO_PC,                      6'd0, NO_LSU, AWAKE);
    add_row("irq_first",  EV_ONE,  NO_PC,                      6'd0, NO_LSU, AWAKE);
    add_row("irq_second", EV_ONE,  NO_PC,                      6'd0, NO_LSU, AWAKE);
    add_row("dbd_set",    EV_NONE, {1'b1, PC_EXC, EXC_PC_DBD}, 6'd0, NO_LSU, AWAKE);
    add_row("dbd_next",   EV_ONE,  NO_PC,                      6'd0, NO_LSU, AWAKE);
    add_row("illegal",    EV_ONE | EV_ILL, NO_PC,              6'd0, NO_LSU, AWAKE);
    add_row("drain_a",    EV_NONE, NO_PC,                      6'd0, NO_LSU, AWAKE);
    add_row("drain_b",    EV_NONE, NO_PC,                      6'd0, NO_LSU, AWAKE);
  endtask

  task automatic drive_row(row_t r);
    {instr_new_i, instr_ret_i, instr_is_compressed_i, illegal_insn_i} = r.ev;
    pc_set_i         = r.pc[5];
    pc_mux_i         = pc_sel_e'(r.pc[4:2]);
    exc_pc_mux_i     = exc_pc_sel_e'(r.pc[1:0]);
    rd_we_i          = r.rd[5];
    rd_addr_i        = r.rd[4:0];
    lsu_data_valid_i = r.lsu[3];
    data_size_i      = mem_size_e'(r.lsu[2:1]);
    data_we_i        = r.lsu[0];
    {if_busy_i, ctrl_busy_i, lsu_busy_i, firstfetch_i} = r.slp[6:3];
    {debug_req_i, irq_pending_i, irq_nm_i} = r.slp[2:0];
    // Don't-care data, fresh every cycle
    instr_rdata_i   = $urandom();
    instr_rdata_c_i = 16'($urandom());
    pc_if_i         = $urandom();
    pc_id_i         = $urandom();
    rs1_addr_i      = 5'($urandom());
    rs2_addr_i      = 5'($urandom());
    rs1_rdata_i     = $urandom();
    rs2_rdata_i     = $urandom();
    rd_wdata_i      = $urandom();
    lsu_addr_i      = $urandom();
    lsu_rdata_i     = $urandom();
    lsu_wdata_i     = $urandom();
  endtask

  // Expected record for the next edge, then the model's next state
  task automatic model_step();
    logic              is_open;
    logic              entry;
    logic [MASK_W-1:0] mask;
    is_open = instr_new_i | m_open;
    entry   = pc_set_i && (pc_mux_i == PC_EXC) &&
              ((exc_pc_mux_i == EXC_PC_EXC) || (exc_pc_mux_i == EXC_PC_IRQ));
    mask    = size_to_mask(data_size_i);
    if (instr_new_i) begin
      m_rs1 = rs1_rdata_i;
      m_rs2 = rs2_rdata_i;
    end
    if (is_open) begin
      m_rd_addr = rd_we_i ? rd_addr_i : '0;
      m_rd_data = (rd_we_i && (rd_addr_i != '0)) ? rd_wdata_i : '0;
    end
    if (is_open && lsu_data_valid_i) begin
      m_addr  = lsu_addr_i;
      m_rdata = lsu_rdata_i;
      m_wdata = lsu_wdata_i;
    end
    exp_rec.order     = exp_rec.order + ORDER_W'(exp_rec.valid);
    exp_rec.valid     = instr_ret_i;
    exp_rec.insn      = instr_is_compressed_i ? {16'b0, instr_rdata_c_i} : instr_rdata_i;
    exp_rec.trap      = illegal_insn_i;
    exp_rec.intr      = m_trap & is_open;
    exp_rec.rs1_addr  = rs1_addr_i;
    exp_rec.rs2_addr  = rs2_addr_i;
    exp_rec.rs1_data  = m_rs1;
    exp_rec.rs2_data  = m_rs2;
    exp_rec.rd_addr   = m_rd_addr;
    exp_rec.rd_data   = m_rd_data;
    exp_rec.pc_rdata  = pc_id_i;
    exp_rec.pc_wdata  = pc_if_i;
    exp_rec.mem_addr  = m_addr;
    exp_rec.rmask     = mask;
    exp_rec.wmask     = data_we_i ? mask : '0;
    exp_rec.mem_rdata = m_rdata;
    exp_rec.mem_wdata = m_wdata;
    m_open = instr_ret_i ? 1'b0 : is_open;
    if (entry) begin
      m_trap = 1'b1;
    end else if (instr_ret_i) begin
      m_trap = 1'b0;
    end
    m_busy = if_busy_i | ctrl_busy_i | lsu_busy_i;
  endtask

  initial begin
    void'($urandom(32'h7b03));
    n_checks  = 0;
    n_errors  = 0;
    exp_rec   = '0;
    m_open    = 1'b0;
    m_trap    = 1'b0;
    m_busy    = 1'b0;
    m_rs1     = '0;
    m_rs2     = '0;
    m_rd_addr = '0;
    m_rd_data = '0;
    m_addr    = '0;
    m_rdata   = '0;
    m_wdata   = '0;
    rst_ni    = 1'b0;
    build_table();
    drive_row(rows[0]);
    table_ready = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    #1;
    rst_ni = 1'b1;
    prev_name = "reset";
    foreach (rows[i]) begin
      @(posedge clk);
      #1;
      check_record(prev_name);
      drive_row(rows[i]);
      #1;
      // Wake sources act at once, busy only after the register
      check_bit({row_names[i], ".sleep"},
                ~(firstfetch_i | m_busy | debug_req_i | irq_pending_i | irq_nm_i),
                core_sleep_o);
      model_step();
      prev_name = row_names[i];
    end
    @(posedge clk);
    #1;
    check_record(prev_name);
    $display("checks %0d errors %0d", n_checks, n_errors);
    if (n_errors == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

  // Watchdog
  initial begin
    wait (table_ready);
    #((rows.size() + 40) * PERIOD);
    $display("timeout after %0d cycles, the stimulus loop did not finish", rows.size() + 40);
    $display("Result: FAILED");
    $finish;
  end

endmodule
